/* common/lsu_ctrl_pkg.sv */
package lsu_ctrl_pkg;

    // Owner of the shared memory port in the current cycle
    typedef enum logic [1:0] {
        GNT_NONE   = 2'd0,
        GNT_COMMIT = 2'd1,
        GNT_LOAD   = 2'd2
    } grant_t;

    // Occupancy of the speculative load queue
    typedef enum logic [1:0] {
        LQ_EMPTY = 2'd0,
        LQ_ONE   = 2'd1,
        LQ_FULL  = 2'd2
    } lq_state_t;

endpackage

/* common/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Data memory geometry

`define DMEM_WORDS 2048  // Words in the data memory
`define DMEM_AW    11    // Word address width

`define XLEN       32    // Data path width

`endif

/* common/mem_op_pkg.sv */
package mem_op_pkg;

    // Memory access width and extension, encoded as the RV32 funct3 field.
    // Codes outside this list are carried through the same type and mean
    // no operation: stores write nothing and loads return zero.
    typedef enum logic [2:0] {
        OP_B  = 3'd0,  // Byte, sign extended
        OP_H  = 3'd1,  // Halfword, sign extended
        OP_W  = 3'd2,  // Full word
        OP_BU = 3'd4,  // Byte, zero extended
        OP_HU = 3'd5   // Halfword, zero extended
    } mem_op_t;

endpackage

/* data_memory/data_memory.sv */
`include "lsu_macros.svh"

module data_memory
    import mem_op_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_we,
    input  logic [`DMEM_AW-1:0]  mem_addr,
    input  mem_op_t              mem_op,
    input  logic [`XLEN-1:0]     mem_wdata,
    output logic [`XLEN-1:0]     mem_rword
);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= `XLEN'(i + 3);  // Known pattern, word i holds i+3
            end
        end else if (mem_we) begin
            case (mem_op)
                OP_B: begin
                    mem[mem_addr][7:0] <= mem_wdata[7:0];  // Low byte lane only
                end
                OP_H: begin
                    mem[mem_addr][15:0] <= mem_wdata[15:0];  // Low halfword lane only
                end
                OP_W: begin
                    mem[mem_addr] <= mem_wdata;
                end
                default: begin
                    // Unsigned and unknown codes store nothing
                end
            endcase
        end
    end

    // Raw word, lane selection happens in load_align
    assign mem_rword = mem[mem_addr];

endmodule

/* data_memory/load_align.sv */
`include "lsu_macros.svh"

module load_align
    import mem_op_pkg::*;
(
    input  logic [`XLEN-1:0] rword,
    input  mem_op_t          op,
    output logic [`XLEN-1:0] rdata
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    assign byte_lane = rword[7:0];
    assign half_lane = rword[15:0];

    always_comb begin
        case (op)
            OP_B: begin
                rdata = {{(`XLEN-8){byte_lane[7]}}, byte_lane};  // Sign from bit 7
            end
            OP_H: begin
                rdata = {{(`XLEN-16){half_lane[15]}}, half_lane};  // Sign from bit 15
            end
            OP_W: begin
                rdata = rword;
            end
            OP_BU: begin
                rdata = {{(`XLEN-8){1'b0}}, byte_lane};
            end
            OP_HU: begin
                rdata = {{(`XLEN-16){1'b0}}, half_lane};
            end
            default: begin
                rdata = '0;  // Unknown funct3 loads zero
            end
        endcase
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Error limit raised so the testbench sees assertion failures itself
./obj_dir/lsu_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    echo "Run passed"
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

/* src.f */
+incdir+common
common/mem_op_pkg.sv
common/lsu_ctrl_pkg.sv
data_memory/data_memory.sv
data_memory/load_align.sv
src/mem_arbiter.sv
src/load_unit.sv
src/commit_unit.sv
src/lsu_top.sv
tb/lsu_assertions.sv
tb/lsu_tb.sv

/* src/commit_unit.sv */
`include "lsu_macros.svh"

module commit_unit
    import mem_op_pkg::*;
    import lsu_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                cm_store,
    input  logic                cm_load,
    input  logic [`DMEM_AW-1:0] cm_addr,
    input  mem_op_t             cm_op,
    input  logic [`XLEN-1:0]    cm_wdata,
    input  logic [`XLEN-1:0]    cm_expect,
    output logic                cu_req,
    output logic                cu_write,
    output logic [`DMEM_AW-1:0] cu_addr,
    output mem_op_t             cu_op,
    output logic [`XLEN-1:0]    cu_wdata,
    input  grant_t              gnt,
    input  logic [`XLEN-1:0]    mem_rdata,
    output logic                cm_done,
    output logic                cm_exception
);

    logic granted;
    logic recheck;
    logic mismatch;

    // Strobes go straight to the port, commit never waits
    assign cu_req   = cm_store || cm_load;
    assign cu_write = cm_store;
    assign cu_addr  = cm_addr;
    assign cu_op    = cm_op;
    assign cu_wdata = cm_wdata;

    assign granted = (gnt == GNT_COMMIT);

    // A store strobe takes precedence if both are raised
    assign recheck = granted && cm_load && !cm_store;

    // Aligned value from memory against what the speculative load saw.
    // A store in the previous cycle is already in the array by now, so
    // the recheck observes it.
    assign mismatch = (mem_rdata != cm_expect);

    always_ff @(posedge clk) begin
        if (reset) begin
            cm_done      <= 1'b0;
            cm_exception <= 1'b0;
        end else begin
            cm_done      <= granted;
            cm_exception <= recheck && mismatch;  // Memory-order violation
        end
    end

endmodule

/* src/load_unit.sv */
`include "lsu_macros.svh"

module load_unit
    import mem_op_pkg::*;
    import lsu_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                ld_req,
    input  logic [`DMEM_AW-1:0] ld_addr,
    input  mem_op_t             ld_op,
    output logic                ld_ready,
    output logic                lu_req,
    output logic [`DMEM_AW-1:0] lu_addr,
    output mem_op_t             lu_op,
    input  grant_t              gnt,
    input  logic [`XLEN-1:0]    mem_rdata,
    output logic                ld_valid,
    output logic [`XLEN-1:0]    ld_data
);

    logic [`DMEM_AW-1:0] addr_q [2];
    mem_op_t             op_q   [2];
    logic                rd_ptr;
    logic                wr_ptr;
    lq_state_t           lq_state;
    logic                push;
    logic                pop;

    assign ld_ready = (lq_state != LQ_FULL);
    assign push     = ld_req && ld_ready;  // Request while full is dropped
    assign pop      = (gnt == GNT_LOAD);

    // Head entry goes to the arbiter
    assign lu_req  = (lq_state != LQ_EMPTY);
    assign lu_addr = addr_q[rd_ptr];
    assign lu_op   = op_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= ld_addr;
            op_q[wr_ptr]   <= ld_op;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr   <= 1'b0;
            wr_ptr   <= 1'b0;
            lq_state <= LQ_EMPTY;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            case (lq_state)
                LQ_EMPTY: if (push) lq_state <= LQ_ONE;
                LQ_ONE:   if (push && !pop) lq_state <= LQ_FULL;
                          else if (pop && !push) lq_state <= LQ_EMPTY;
                LQ_FULL:  if (pop) lq_state <= LQ_ONE;  // No push while full
                default:  lq_state <= LQ_EMPTY;
            endcase
        end
    end

    // Result one cycle after the grant
    always_ff @(posedge clk) begin
        if (reset) begin
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) ld_data <= mem_rdata;
    end

endmodule

/* src/lsu_top.sv */
`include "lsu_macros.svh"

module lsu_top
    import mem_op_pkg::*;
    import lsu_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                ld_req,
    input  logic [`DMEM_AW-1:0] ld_addr,
    input  mem_op_t             ld_op,
    output logic                ld_ready,
    output logic                ld_valid,
    output logic [`XLEN-1:0]    ld_data,
    input  logic                cm_store,
    input  logic                cm_load,
    input  logic [`DMEM_AW-1:0] cm_addr,
    input  mem_op_t             cm_op,
    input  logic [`XLEN-1:0]    cm_wdata,
    input  logic [`XLEN-1:0]    cm_expect,
    output logic                cm_done,
    output logic                cm_exception
);

    logic                lu_req;
    logic [`DMEM_AW-1:0] lu_addr;
    mem_op_t             lu_op;
    logic                cu_req;
    logic                cu_write;
    logic [`DMEM_AW-1:0] cu_addr;
    mem_op_t             cu_op;
    logic [`XLEN-1:0]    cu_wdata;
    grant_t              gnt;
    logic                mem_we;
    logic [`DMEM_AW-1:0] mem_addr;
    mem_op_t             mem_op;
    logic [`XLEN-1:0]    mem_wdata;
    logic [`XLEN-1:0]    mem_rword;
    logic [`XLEN-1:0]    mem_rdata;  // Aligned read, shared by both units

    load_unit load_unit_i (
        .clk(clk), .reset(reset),
        .ld_req(ld_req), .ld_addr(ld_addr), .ld_op(ld_op), .ld_ready(ld_ready),
        .lu_req(lu_req), .lu_addr(lu_addr), .lu_op(lu_op),
        .gnt(gnt), .mem_rdata(mem_rdata),
        .ld_valid(ld_valid), .ld_data(ld_data)
    );

    commit_unit commit_unit_i (
        .clk(clk), .reset(reset),
        .cm_store(cm_store), .cm_load(cm_load), .cm_addr(cm_addr), .cm_op(cm_op),
        .cm_wdata(cm_wdata), .cm_expect(cm_expect),
        .cu_req(cu_req), .cu_write(cu_write), .cu_addr(cu_addr), .cu_op(cu_op),
        .cu_wdata(cu_wdata), .gnt(gnt), .mem_rdata(mem_rdata),
        .cm_done(cm_done), .cm_exception(cm_exception)
    );

    mem_arbiter mem_arbiter_i (
        .cu_req(cu_req), .cu_write(cu_write), .cu_addr(cu_addr), .cu_op(cu_op),
        .cu_wdata(cu_wdata), .lu_req(lu_req), .lu_addr(lu_addr), .lu_op(lu_op),
        .gnt(gnt), .mem_we(mem_we), .mem_addr(mem_addr), .mem_op(mem_op),
        .mem_wdata(mem_wdata)
    );

    data_memory data_memory_i (
        .clk(clk), .reset(reset), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_op(mem_op), .mem_wdata(mem_wdata), .mem_rword(mem_rword)
    );

    load_align load_align_i (
        .rword(mem_rword), .op(mem_op), .rdata(mem_rdata)
    );

endmodule

/* src/mem_arbiter.sv */
`include "lsu_macros.svh"

module mem_arbiter
    import mem_op_pkg::*;
    import lsu_ctrl_pkg::*;
(
    input  logic                cu_req,
    input  logic                cu_write,
    input  logic [`DMEM_AW-1:0] cu_addr,
    input  mem_op_t             cu_op,
    input  logic [`XLEN-1:0]    cu_wdata,
    input  logic                lu_req,
    input  logic [`DMEM_AW-1:0] lu_addr,
    input  mem_op_t             lu_op,
    output grant_t              gnt,
    output logic                mem_we,
    output logic [`DMEM_AW-1:0] mem_addr,
    output mem_op_t             mem_op,
    output logic [`XLEN-1:0]    mem_wdata
);

    logic commit_won;

    // Commit side always wins, loads only get idle cycles
    always_comb begin
        if (cu_req) begin
            gnt = GNT_COMMIT;
        end else if (lu_req) begin
            gnt = GNT_LOAD;
        end else begin
            gnt = GNT_NONE;
        end
    end

    assign commit_won = (gnt == GNT_COMMIT);

    // Port steering, the load side parks on the port when nobody asks
    assign mem_addr  = commit_won ? cu_addr : lu_addr;
    assign mem_op    = commit_won ? cu_op : lu_op;
    assign mem_wdata = commit_won ? cu_wdata : '0;  // Loads carry no write data
    assign mem_we    = commit_won && cu_write;

endmodule

/* tb/lsu_assertions.sv */
module lsu_assertions
    import lsu_ctrl_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      cu_req,
    input grant_t    gnt,
    input logic      mem_we,
    input logic      ld_valid,
    input logic      cm_done,
    input logic      ld_req,
    input lq_state_t lq_state
);

    timeunit 1ns;
    timeprecision 100ps;

    int assert_errors = 0;  // Read by the testbench

    logic [1:0] pending;  // Loads taken in and not yet granted

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 2'd0;
        end else begin
            pending <= pending + 2'(ld_req) - 2'(gnt == GNT_LOAD);
        end
    end

    // Commit request keeps loads off the port
    commit_priority: assert property (@(posedge clk) disable iff (reset)
        cu_req |-> gnt != GNT_LOAD)
    else begin
        assert_errors++;
        $error("load granted while a commit request is up");
    end

    write_owner: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> gnt == GNT_COMMIT)
    else begin
        assert_errors++;
        $error("memory write without a commit grant");
    end

    reset_quiet: assert property (@(posedge clk)
        $past(reset) && !reset |-> !ld_valid && !cm_done)
    else begin
        assert_errors++;
        $error("result strobe active right after reset");
    end

    // Two entries at most, occupancy follows requests and grants
    queue_bound: assert property (@(posedge clk) disable iff (reset)
        pending != 2'd3 && pending == lq_state)
    else begin
        assert_errors++;
        $error("load queue beyond two entries");
    end

endmodule

bind lsu_top lsu_assertions lsu_assertions_i (
    .clk(clk), .reset(reset), .cu_req(cu_req), .gnt(gnt), .mem_we(mem_we),
    .ld_valid(ld_valid), .cm_done(cm_done), .ld_req(ld_req),
    .lq_state(load_unit_i.lq_state)
);

/* tb/lsu_tb.sv */
`include "lsu_macros.svh"

module lsu_tb
    import mem_op_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TEST_CYCLES    = 3000;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 200;
    localparam int LOAD_ONLY_END  = 200;   // Loads of untouched words only
    localparam int DENSE_START    = 2200;  // Commit strobe in most cycles
    localparam logic [`DMEM_AW-1:0] WINDOW_BASE = 11'h07C;  // Byte values cross 0x80 here

    logic                clk;
    logic                reset;
    logic                ld_req;
    logic [`DMEM_AW-1:0] ld_addr;
    mem_op_t             ld_op;
    logic                ld_ready;
    logic                ld_valid;
    logic [`XLEN-1:0]    ld_data;
    logic                cm_store;
    logic                cm_load;
    logic [`DMEM_AW-1:0] cm_addr;
    mem_op_t             cm_op;
    logic [`XLEN-1:0]    cm_wdata;
    logic [`XLEN-1:0]    cm_expect;
    logic                cm_done;
    logic                cm_exception;

    // Reference model state
    logic [`XLEN-1:0]    model_mem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] mq_addr [$];  // Loads waiting in the queue
    mem_op_t             mq_op [$];
    logic [`XLEN-1:0]    exp_results [$];
    logic                exp_valid;
    logic                exp_done;
    logic                exp_exc;

    integer seed;
    string  test_name;
    bit     saw_full;
    int     cycle_count = 0;
    int     loads_checked = 0;
    int     rechecks = 0;
    int     exceptions_seen = 0;

    lsu_top lsu_top_i (
        .clk(clk), .reset(reset),
        .ld_req(ld_req), .ld_addr(ld_addr), .ld_op(ld_op), .ld_ready(ld_ready),
        .ld_valid(ld_valid), .ld_data(ld_data),
        .cm_store(cm_store), .cm_load(cm_load), .cm_addr(cm_addr), .cm_op(cm_op),
        .cm_wdata(cm_wdata), .cm_expect(cm_expect),
        .cm_done(cm_done), .cm_exception(cm_exception)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    // Bound assertions count their failures
    always @(negedge clk) begin
        if (lsu_top_i.lsu_assertions_i.assert_errors != 0) begin
            $display("A bound assertion failed in test %s", test_name);
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failure");
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [`DMEM_AW-1:0] window_addr();
        return WINDOW_BASE + `DMEM_AW'(rand_below(16));
    endfunction

    function automatic mem_op_t random_op();
        return mem_op_t'(3'(rand_below(8)));  // Invalid codes included
    endfunction

    // funct3 load rule, extension from the lane's own top bit
    function automatic logic [`XLEN-1:0] extend_lane(input logic [`XLEN-1:0] word,
                                                     input mem_op_t op);
        logic [`XLEN-1:0] result;
        case (op)
            OP_B:    result = `XLEN'($signed(word[7:0]));
            OP_H:    result = `XLEN'($signed(word[15:0]));
            OP_W:    result = word;
            OP_BU:   result = `XLEN'(word[7:0]);
            OP_HU:   result = `XLEN'(word[15:0]);
            default: result = '0;
        endcase
        return result;
    endfunction

    task automatic apply_store(input logic [`DMEM_AW-1:0] addr, input mem_op_t op,
                               input logic [`XLEN-1:0] data);
        logic [`XLEN-1:0] mask;
        case (op)
            OP_B:    mask = 32'h0000_00ff;
            OP_H:    mask = 32'h0000_ffff;
            OP_W:    mask = 32'hffff_ffff;
            default: mask = 32'h0;  // Nothing written
        endcase
        model_mem[addr] = (model_mem[addr] & ~mask) | (data & mask);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s/%s expected %h actual %h", test_name, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // Outputs of the cycle that just ended, stable at the falling edge
    task automatic check_outputs();
        check_value("ld_ready", 32'(mq_addr.size() < 2), 32'(ld_ready));
        if (!ld_ready) saw_full = 1'b1;
        check_value("ld_valid", 32'(exp_valid), 32'(ld_valid));
        if (exp_valid) begin
            check_value("ld_data", exp_results.pop_front(), ld_data);
            loads_checked++;
        end
        check_value("cm_done", 32'(exp_done), 32'(cm_done));
        check_value("cm_exception", 32'(exp_exc), 32'(cm_exception));
        if (cm_exception) exceptions_seen++;
    endtask

    // Phase 0 loads only, 1 mixed, 2 dense commit, 3 drain
    task automatic drive_cycle(input int phase);
        int                  action;
        bit                  ready;
        logic [`DMEM_AW-1:0] addr;
        mem_op_t             op;
        logic [`XLEN-1:0]    aligned;
        ready     = (mq_addr.size() < 2);
        ld_req    = 1'b0;
        cm_store  = 1'b0;
        cm_load   = 1'b0;
        cm_addr   = '0;
        cm_op     = OP_B;
        cm_wdata  = '0;
        cm_expect = '0;
        case (phase)
            1:       action = rand_below(3);  // 0 none, 1 store, 2 recheck
            2:       action = (rand_below(8) == 0) ? 0 : 1 + rand_below(2);
            default: action = 0;
        endcase
        addr     = window_addr();
        op       = random_op();
        exp_done = (action != 0);
        exp_exc  = 1'b0;
        if (action != 0) begin
            cm_addr = addr;
            cm_op   = op;
        end
        if (action == 1) begin
            cm_store = 1'b1;
            cm_wdata = $random(seed);
            apply_store(addr, op, cm_wdata);  // Written at the closing edge
        end else if (action == 2) begin
            aligned   = extend_lane(model_mem[addr], op);
            cm_load   = 1'b1;
            cm_expect = (rand_below(2) == 0) ? aligned
                                             : aligned ^ (32'($random(seed)) | 32'd1);
            exp_exc   = (aligned != cm_expect);
            rechecks++;
        end
        // Head load owns the port only when commit is idle
        exp_valid = 1'b0;
        if (action == 0 && mq_addr.size() != 0) begin
            exp_results.push_back(extend_lane(model_mem[mq_addr[0]], mq_op[0]));
            void'(mq_addr.pop_front());
            void'(mq_op.pop_front());
            exp_valid = 1'b1;
        end
        if (phase != 3 && ready && rand_below(4) != 0) begin
            ld_req  = 1'b1;
            ld_addr = (phase == 0) ? `DMEM_AW'(rand_below(`DMEM_WORDS)) : window_addr();
            ld_op   = random_op();
            mq_addr.push_back(ld_addr);
            mq_op.push_back(ld_op);
        end
    endtask

    initial begin
        seed      = 32'h9263_a9bd;
        saw_full  = 1'b0;
        test_name = "reset";
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            model_mem[i] = `XLEN'(i + 3);
        end
        reset     = 1'b1;
        ld_req    = 1'b0;
        ld_addr   = '0;
        ld_op     = OP_B;
        cm_store  = 1'b0;
        cm_load   = 1'b0;
        cm_addr   = '0;
        cm_op     = OP_B;
        cm_wdata  = '0;
        cm_expect = '0;
        exp_valid = 1'b0;
        exp_done  = 1'b0;
        exp_exc   = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
            @(negedge clk);
            check_outputs();
            if (cyc < LOAD_ONLY_END) begin
                test_name = "reset_contents";
                drive_cycle(0);
            end else if (cyc < DENSE_START) begin
                test_name = "mixed_traffic";
                drive_cycle(1);
            end else begin
                test_name = "dense_commit";
                drive_cycle(2);
            end
        end

        test_name = "drain";
        while (mq_addr.size() != 0 || exp_valid || exp_done) begin
            @(negedge clk);
            check_outputs();
            drive_cycle(3);
        end

        $display("Loads checked %0d, rechecks %0d, exceptions %0d",
                 loads_checked, rechecks, exceptions_seen);
        if (!saw_full) begin
            $display("Back-pressure never seen, ld_ready stayed high for the whole run");
            $display("Simulation finished: FAIL");
            $fatal(1, "no back-pressure");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
